// ==== sim.f ====
+incdir+test
source/dcache_pkg.sv
source/tag_array.sv
source/lru_tracker.sv
source/data_array.sv
source/dcache_top.sv
test/tb_dcache.sv

// ==== source/data_array.sv ====
// ---------------------------------------------------------------------
// Cache line storage.
// Byte merge for aligned stores, line refill and the read ports.
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module data_array #(
    parameter int WAYS = 4
) (
    input  logic                            clk,
    input  dcache_pkg::dcache_addr_t        i_addr,
    input  logic [dcache_pkg::DWORD_W-1:0]  i_wdata,
    input  dcache_pkg::store_size_e         i_size,
    input  logic                            i_store,
    input  logic                            i_refill,
    input  dcache_pkg::line_t               i_line,
    input  logic [$clog2(WAYS)-1:0]         i_sel_way,
    input  logic [$clog2(WAYS)-1:0]         i_victim_way,
    output logic [dcache_pkg::DWORD_W-1:0]  o_rdata,
    output dcache_pkg::line_t               o_line
);

    import dcache_pkg::*;

    localparam int BYTES = DWORD_W / 8;

    line_t data_mem [SETS][WAYS];

    line_t              sel_line;
    logic [DWORD_W-1:0] rdata;
    logic [BYTES-1:0]   size_mask;
    logic [BYTES-1:0]   byte_mask;
    logic [DWORD_W-1:0] wdata_shift;
    logic [DWORD_W-1:0] merged;
    logic               aligned;

    // -----------------------------------------------------------------
    // Read
    // -----------------------------------------------------------------

    assign sel_line = data_mem[i_addr.index][i_sel_way];
    assign rdata    = sel_line[i_addr.offset * DWORD_W +: DWORD_W];
    assign o_rdata  = rdata;
    assign o_line   = sel_line;

    // -----------------------------------------------------------------
    // Store merge
    // -----------------------------------------------------------------

    always_comb begin
        case (i_size)
            SB:      size_mask = 8'h01;
            SH:      size_mask = 8'h03;
            SW:      size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
    end

    // Lanes follow the byte offset.
    assign byte_mask   = size_mask << i_addr.byte_off;
    assign wdata_shift = i_wdata << (i_addr.byte_off * 8);

    always_comb begin
        for (int b = 0; b < BYTES; b++) begin
            merged[b*8 +: 8] = byte_mask[b] ? wdata_shift[b*8 +: 8] : rdata[b*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (i_store) begin
            data_mem[i_addr.index][i_sel_way][i_addr.offset * DWORD_W +: DWORD_W] <= merged;
        end else if (i_refill) begin
            data_mem[i_addr.index][i_victim_way] <= i_line;
        end
    end

    // Natural alignment per access size.
    always_comb begin
        case (i_size)
            SB:      aligned = 1'b1;
            SH:      aligned = (i_addr.byte_off[0] == 1'b0);
            SW:      aligned = (i_addr.byte_off[1:0] == 2'b00);
            default: aligned = (i_addr.byte_off == '0);
        endcase
    end

    a_no_store_refill: assert property (@(posedge clk)
        !(i_store && i_refill));

    a_store_aligned: assert property (@(posedge clk)
        i_store |-> aligned);

endmodule

// ==== source/dcache_pkg.sv ====
// ---------------------------------------------------------------------
// Data cache package.
// Geometry, address fields, request layout and store sizes.
// ---------------------------------------------------------------------

package dcache_pkg;

    // Fixed geometry.
    localparam int ADDR_W         = 32;
    localparam int DWORD_W        = 64;
    localparam int SETS           = 16;
    localparam int WORDS_PER_LINE = 8;
    localparam int LINE_W         = WORDS_PER_LINE * DWORD_W;
    localparam int INDEX_W        = $clog2(SETS);
    localparam int OFFSET_W       = $clog2(WORDS_PER_LINE);
    localparam int BYTE_W         = $clog2(DWORD_W / 8);
    localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W - BYTE_W;

    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [LINE_W-1:0]   line_t;

    // One address word with the tag at the top.
    typedef struct packed {
        tag_t                tag;
        index_t              index;
        offset_t             offset;
        logic [BYTE_W-1:0]   byte_off;
    } dcache_addr_t;

    // Store access sizes.
    typedef enum logic [1:0] {
        SB = 2'b00,
        SH = 2'b01,
        SW = 2'b10,
        SD = 2'b11
    } store_size_e;

    // Request from the core side controller.
    typedef struct packed {
        dcache_addr_t         addr;
        logic [DWORD_W-1:0]   data;
        store_size_e          size;
    } dcache_req_t;

endpackage

// ==== source/dcache_top.sv ====
// ---------------------------------------------------------------------
// Set-associative data cache array, top level.
// Joins the tag, LRU and data blocks around one request.
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module dcache_top #(
    parameter int WAYS = 4
) (
    input  logic                            clk,
    input  logic                            arstn,

    // Request and strobes from the controller.
    input  dcache_pkg::dcache_req_t         i_req,
    input  logic                            i_store,
    input  logic                            i_refill,
    input  logic                            i_touch,
    input  dcache_pkg::line_t               i_line,

    // Lookup results.
    output logic                            o_hit,
    output logic [dcache_pkg::DWORD_W-1:0]  o_rdata,
    output dcache_pkg::line_t               o_line,
    output logic                            o_dirty,
    output logic [dcache_pkg::ADDR_W-1:0]   o_wb_addr
);

    localparam int WAY_W = $clog2(WAYS);

    logic [WAY_W-1:0] victim_way;
    logic [WAY_W-1:0] sel_way;
    logic [WAYS-1:0]  hit_way;

    tag_array #(
        .WAYS (WAYS)
    ) u_tag_array (
        .clk          (clk),
        .arstn        (arstn),
        .i_addr       (i_req.addr),
        .i_store      (i_store),
        .i_refill     (i_refill),
        .i_victim_way (victim_way),
        .o_hit        (o_hit),
        .o_hit_way    (hit_way),
        .o_sel_way    (sel_way),
        .o_dirty      (o_dirty),
        .o_wb_addr    (o_wb_addr)
    );

    lru_tracker #(
        .WAYS (WAYS)
    ) u_lru_tracker (
        .clk          (clk),
        .arstn        (arstn),
        .i_index      (i_req.addr.index),
        .i_touch      (i_touch),
        .i_hit        (o_hit),
        .i_hit_way    (hit_way),
        .o_victim_way (victim_way)
    );

    data_array #(
        .WAYS (WAYS)
    ) u_data_array (
        .clk          (clk),
        .i_addr       (i_req.addr),
        .i_wdata      (i_req.data),
        .i_size       (i_req.size),
        .i_store      (i_store),
        .i_refill     (i_refill),
        .i_line       (i_line),
        .i_sel_way    (sel_way),
        .i_victim_way (victim_way),
        .o_rdata      (o_rdata),
        .o_line       (o_line)
    );

endmodule

// ==== source/lru_tracker.sv ====
// ---------------------------------------------------------------------
// LRU tracker with one age counter per way and set.
// Age 0 marks the victim and a touch makes the hit way youngest.
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module lru_tracker #(
    parameter int WAYS = 4
) (
    input  logic                     clk,
    input  logic                     arstn,
    input  dcache_pkg::index_t       i_index,
    input  logic                     i_touch,
    input  logic                     i_hit,
    input  logic [WAYS-1:0]          i_hit_way,
    output logic [$clog2(WAYS)-1:0]  o_victim_way
);

    import dcache_pkg::*;

    localparam int WAY_W = $clog2(WAYS);

    logic [SETS-1:0][WAYS-1:0][WAY_W-1:0] age_q;

    logic [WAY_W-1:0] hit_age;
    logic             ages_distinct;

    always_comb begin
        hit_age      = '0;
        o_victim_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (i_hit_way[w]) begin
                hit_age = hit_age | age_q[i_index][w];
            end
            if (age_q[i_index][w] == '0) begin
                o_victim_way = WAY_W'(w);
            end
        end
    end

    // Reset order makes way 0 the first victim.
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    age_q[s][w] <= WAY_W'(w);
                end
            end
        end else if (i_touch && i_hit) begin
            for (int w = 0; w < WAYS; w++) begin
                if (i_hit_way[w]) begin
                    age_q[i_index][w] <= WAY_W'(WAYS - 1);
                end else if (age_q[i_index][w] > hit_age) begin
                    age_q[i_index][w] <= age_q[i_index][w] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        ages_distinct = 1'b1;
        for (int a = 0; a < WAYS; a++) begin
            for (int b = a + 1; b < WAYS; b++) begin
                if (age_q[i_index][a] == age_q[i_index][b]) begin
                    ages_distinct = 1'b0;
                end
            end
        end
    end

    a_ages_distinct: assert property (@(posedge clk) disable iff (!arstn)
        ages_distinct);

endmodule

// ==== source/tag_array.sv ====
// ---------------------------------------------------------------------
// Tag array with valid and dirty bits.
// Hit compare over all ways, way select and writeback address.
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module tag_array #(
    parameter int WAYS = 4
) (
    input  logic                           clk,
    input  logic                           arstn,
    input  dcache_pkg::dcache_addr_t       i_addr,
    input  logic                           i_store,
    input  logic                           i_refill,
    input  logic [$clog2(WAYS)-1:0]        i_victim_way,
    output logic                           o_hit,
    output logic [WAYS-1:0]                o_hit_way,
    output logic [$clog2(WAYS)-1:0]        o_sel_way,
    output logic                           o_dirty,
    output logic [dcache_pkg::ADDR_W-1:0]  o_wb_addr
);

    import dcache_pkg::*;

    localparam int WAY_W = $clog2(WAYS);

    // Tag storage per set and way.
    tag_t tag_mem [SETS][WAYS];

    logic [SETS-1:0][WAYS-1:0] valid_q;
    logic [SETS-1:0][WAYS-1:0] dirty_q;

    logic [WAY_W-1:0] hit_idx;
    dcache_addr_t     wb_addr;

    // -----------------------------------------------------------------
    // Lookup
    // -----------------------------------------------------------------

    always_comb begin
        hit_idx = '0;
        for (int w = 0; w < WAYS; w++) begin
            o_hit_way[w] = valid_q[i_addr.index][w] &&
                           (tag_mem[i_addr.index][w] == i_addr.tag);
            if (o_hit_way[w]) begin
                hit_idx = hit_idx | WAY_W'(w);
            end
        end
    end

    assign o_hit     = |o_hit_way;
    assign o_sel_way = o_hit ? hit_idx : i_victim_way;
    assign o_dirty   = dirty_q[i_addr.index][i_victim_way];

    // Victim line address with zero offset bits.
    always_comb begin
        wb_addr          = '0;
        wb_addr.tag      = tag_mem[i_addr.index][i_victim_way];
        wb_addr.index    = i_addr.index;
    end

    assign o_wb_addr = wb_addr;

    // -----------------------------------------------------------------
    // Update
    // -----------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (i_refill) begin
            tag_mem[i_addr.index][i_victim_way] <= i_addr.tag;
        end
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (i_refill) begin
            valid_q[i_addr.index][i_victim_way] <= 1'b1;
            dirty_q[i_addr.index][i_victim_way] <= 1'b0;
        end else if (i_store) begin
            dirty_q[i_addr.index][hit_idx] <= 1'b1;
        end
    end

    // Controller must only store into a resident line.
    a_store_hit: assert property (@(posedge clk) disable iff (!arstn)
        i_store |-> o_hit);

    // Refill never leaves a tag in two ways of a set.
    a_hit_onehot: assert property (@(posedge clk) disable iff (!arstn)
        $onehot0(o_hit_way));

endmodule

// ==== test/dcache_model.svh ====
// ---------------------------------------------------------------------
// Reference model of the data cache array.
// Mirrors tags, valid, dirty, ages and line data per set and way.
// ---------------------------------------------------------------------

`ifndef DCACHE_MODEL_SVH
`define DCACHE_MODEL_SVH

tag_t  m_tag   [SETS][WAYS];
line_t m_data  [SETS][WAYS];
bit    m_valid [SETS][WAYS];
bit    m_dirty [SETS][WAYS];
int    m_age   [SETS][WAYS];

task automatic clear_model();
    for (int s = 0; s < SETS; s++) begin
        for (int w = 0; w < WAYS; w++) begin
            m_valid[s][w] = 1'b0;
            m_dirty[s][w] = 1'b0;
            m_age[s][w]   = w;
        end
    end
endtask

// Returns the hit way or -1 on a miss.
function automatic int lookup_way(dcache_addr_t a);
    for (int w = 0; w < WAYS; w++) begin
        if (m_valid[a.index][w] && m_tag[a.index][w] == a.tag) begin
            return w;
        end
    end
    return -1;
endfunction

function automatic int victim_of(index_t idx);
    int v;
    v = 0;
    for (int w = 0; w < WAYS; w++) begin
        if (m_age[idx][w] == 0) begin
            v = w;
        end
    end
    return v;
endfunction

// The hit way becomes youngest and each more recent way moves down by one.
task automatic touch_ages(dcache_addr_t a);
    int h;
    int ha;
    h = lookup_way(a);
    if (h >= 0) begin
        ha = m_age[a.index][h];
        for (int w = 0; w < WAYS; w++) begin
            if (w == h) begin
                m_age[a.index][w] = WAYS - 1;
            end else if (m_age[a.index][w] > ha) begin
                m_age[a.index][w] = m_age[a.index][w] - 1;
            end
        end
    end
endtask

task automatic store_bytes(dcache_addr_t a, logic [DWORD_W-1:0] d, store_size_e sz);
    int w;
    int nbytes;
    w = lookup_way(a);
    nbytes = 1 << int'(sz);
    for (int b = 0; b < nbytes; b++) begin
        m_data[a.index][w][a.offset * DWORD_W + (a.byte_off + b) * 8 +: 8] = d[b*8 +: 8];
    end
    m_dirty[a.index][w] = 1'b1;
endtask

task automatic refill_victim(dcache_addr_t a, line_t ln);
    int v;
    v = victim_of(a.index);
    m_tag[a.index][v]   = a.tag;
    m_data[a.index][v]  = ln;
    m_valid[a.index][v] = 1'b1;
    m_dirty[a.index][v] = 1'b0;
endtask

`endif

// ==== test/tb_dcache.sv ====
// ---------------------------------------------------------------------
// Testbench for the data cache array.
// Directed phases and a random mix, checked against a model.
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module tb_dcache;

    import dcache_pkg::*;

    localparam int WAYS      = 4;
    localparam int MAX_CYCLE = 3000;
    localparam int TAG_MASK  = (1 << TAG_W) - 1;

    logic               clk;
    logic               arstn;
    dcache_req_t        req;
    logic               store;
    logic               refill;
    logic               touch;
    line_t              line_in;
    logic               hit;
    logic [DWORD_W-1:0] rdata;
    line_t              line_out;
    logic               dirty;
    logic [ADDR_W-1:0]  wb_addr;

    integer seed;
    int     cycles;
    int     n_checks;
    int     n_errors;

    `include "dcache_model.svh"

    dcache_top #(
        .WAYS (WAYS)
    ) uut (
        .clk       (clk),
        .arstn     (arstn),
        .i_req     (req),
        .i_store   (store),
        .i_refill  (refill),
        .i_touch   (touch),
        .i_line    (line_in),
        .o_hit     (hit),
        .o_rdata   (rdata),
        .o_line    (line_out),
        .o_dirty   (dirty),
        .o_wb_addr (wb_addr)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLE) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLE);
            $display("Errors found");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------

    task automatic mismatch(string name, logic [LINE_W-1:0] got, logic [LINE_W-1:0] exp);
        n_errors++;
        $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
    endtask

    function automatic line_t rand_line();
        line_t l;
        for (int i = 0; i < LINE_W / 32; i++) begin
            l[i*32 +: 32] = $random(seed);
        end
        return l;
    endfunction

    function automatic dcache_addr_t rand_addr(int tag_mask, int set_mask);
        dcache_addr_t a;
        a.tag      = tag_t'($random(seed) & tag_mask);
        a.index    = index_t'($random(seed) & set_mask);
        a.offset   = offset_t'($random(seed));
        a.byte_off = 3'($random(seed));
        return a;
    endfunction

    function automatic dcache_addr_t align(dcache_addr_t a, store_size_e sz);
        case (sz)
            SH:      a.byte_off[0]   = 1'b0;
            SW:      a.byte_off[1:0] = 2'b00;
            SD:      a.byte_off      = '0;
            default: a.byte_off      = a.byte_off;
        endcase
        return a;
    endfunction

    // Outputs against the model state before this cycle's update.
    task automatic check_outputs();
        int           h;
        int           v;
        index_t       idx;
        dcache_addr_t wb;
        idx = req.addr.index;
        h   = lookup_way(req.addr);
        v   = victim_of(idx);
        n_checks++;
        if (hit !== (h >= 0)) begin
            mismatch("o_hit", hit, h >= 0);
        end
        if (dirty !== m_dirty[idx][v]) begin
            mismatch("o_dirty", dirty, m_dirty[idx][v]);
        end
        if (h >= 0) begin
            if (rdata !== m_data[idx][h][req.addr.offset * DWORD_W +: DWORD_W]) begin
                mismatch("o_rdata", rdata, m_data[idx][h][req.addr.offset * DWORD_W +: DWORD_W]);
            end
            if (line_out !== m_data[idx][h]) begin
                mismatch("o_line", line_out, m_data[idx][h]);
            end
        end else if (m_valid[idx][v]) begin
            if (rdata !== m_data[idx][v][req.addr.offset * DWORD_W +: DWORD_W]) begin
                mismatch("o_rdata", rdata, m_data[idx][v][req.addr.offset * DWORD_W +: DWORD_W]);
            end
            if (line_out !== m_data[idx][v]) begin
                mismatch("o_line", line_out, m_data[idx][v]);
            end
        end
        if (m_valid[idx][v]) begin
            wb       = '0;
            wb.tag   = m_tag[idx][v];
            wb.index = idx;
            if (wb_addr !== wb) begin
                mismatch("o_wb_addr", wb_addr, wb);
            end
        end
    endtask

    // One cycle that drives on the rising edge and checks at the falling edge.
    task automatic step(dcache_addr_t a, logic st, logic rf, logic tc, store_size_e sz);
        logic [DWORD_W-1:0] d;
        line_t              ln;
        d  = {$random(seed), $random(seed)};
        ln = rand_line();
        @(posedge clk);
        req.addr <= a;
        req.data <= d;
        req.size <= sz;
        store    <= st;
        refill   <= rf;
        touch    <= tc;
        line_in  <= ln;
        @(negedge clk);
        check_outputs();
        if (tc) begin
            touch_ages(a);
        end
        if (rf) begin
            refill_victim(a, ln);
        end else if (st) begin
            store_bytes(a, d, sz);
        end
    endtask

    task automatic report_test(int num, string name, int start);
        $display("Test %0d %s finished with %0d failures", num, name, n_errors - start);
    endtask

    // ------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------

    initial begin
        dcache_addr_t a;
        dcache_addr_t exp_wb;
        store_size_e  sz;
        tag_t         base;
        int           order [4];
        int           start;
        int           op;
        int           j;
        int           tmp;
        seed     = 3;
        cycles   = 0;
        n_checks = 0;
        n_errors = 0;
        clk      = 1'b0;
        arstn    = 1'b0;
        req      = '0;
        store    = 1'b0;
        refill   = 1'b0;
        touch    = 1'b0;
        line_in  = '0;
        clear_model();
        repeat (2) @(posedge clk);
        arstn <= 1'b1;

        start = n_errors;
        repeat (20) begin
            step(rand_addr(TAG_MASK, SETS - 1), 1'b0, 1'b0, 1'b0, SD);
        end
        report_test(1, "reset lookups", start);

        start = n_errors;
        repeat (6) begin
            a = rand_addr(TAG_MASK, SETS - 1);
            step(a, 1'b0, lookup_way(a) < 0, 1'b0, SD);
            step(a, 1'b0, 1'b0, 1'b1, SD);
            for (int off = 0; off < WORDS_PER_LINE; off++) begin
                a.offset = offset_t'(off);
                step(a, 1'b0, 1'b0, 1'b0, SD);
            end
        end
        report_test(2, "refill and read", start);

        start = n_errors;
        repeat (60) begin
            a = rand_addr(3, 3);
            if (lookup_way(a) < 0) begin
                step(a, 1'b0, 1'b1, 1'b0, SD);
            end
            sz = store_size_e'($random(seed) & 3);
            a  = align(a, sz);
            step(a, 1'b1, 1'b0, 1'b0, sz);
            step(a, 1'b0, 1'b0, 1'b0, SD);
        end
        report_test(3, "aligned stores", start);

        start    = n_errors;
        base     = tag_t'($random(seed) & TAG_MASK) | tag_t'(1 << (TAG_W - 1));
        a        = rand_addr(0, 0);
        a.index  = index_t'(12);
        for (int k = 0; k < 4; k++) begin
            a.tag = base + tag_t'(k);
            step(a, 1'b0, 1'b1, 1'b0, SD);
            step(a, 1'b0, 1'b0, 1'b1, SD);
        end
        a.tag      = base + tag_t'($unsigned($random(seed)) % 4);
        a.byte_off = '0;
        step(a, 1'b1, 1'b0, 1'b0, SD);
        for (int i = 0; i < 4; i++) begin
            order[i] = i;
        end
        for (int i = 3; i > 0; i--) begin
            j        = $unsigned($random(seed)) % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 4; i++) begin
            a.tag = base + tag_t'(order[i]);
            step(a, 1'b0, 1'b0, 1'b1, SD);
        end
        a.tag = base + tag_t'(4);
        step(a, 1'b0, 1'b0, 1'b0, SD);
        exp_wb       = '0;
        exp_wb.tag   = base + tag_t'(order[0]);
        exp_wb.index = a.index;
        n_checks++;
        if (hit !== 1'b0) begin
            mismatch("o_hit", hit, 1'b0);
        end
        if (wb_addr !== exp_wb) begin
            mismatch("o_wb_addr", wb_addr, exp_wb);
        end
        report_test(4, "LRU victim", start);

        start = n_errors;
        repeat (400) begin
            a  = rand_addr(3, 3);
            op = $unsigned($random(seed)) % 4;
            sz = store_size_e'($random(seed) & 3);
            if (op == 2 && lookup_way(a) >= 0) begin
                step(align(a, sz), 1'b1, 1'b0, 1'b0, sz);
            end else if (op == 3 && lookup_way(a) < 0) begin
                step(a, 1'b0, 1'b1, 1'b0, SD);
            end else begin
                step(a, 1'b0, 1'b0, op != 0, SD);
            end
        end
        step(a, 1'b0, 1'b0, 1'b0, SD);
        report_test(5, "random mix", start);

        $display("Summary: %0d checks, %0d mismatches", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
